//--- Makefile
# Verilator build and run of the execute stage testbench

TOP       ?= tb_execute_stage
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator, run $(TOP), check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "variables: TOP FILELIST BUILD_DIR LOG VERILATOR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o $(TOP)
	./$(BUILD_DIR)/$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "Simulation failed" $(LOG); then echo "test: FAILED"; exit 1; fi
	@if ! grep -q "Simulation completed successfully" $(LOG); then echo "test: no result"; exit 1; fi
	@echo "test: PASSED"

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- alu_unit.sv
`timescale 1ns/1ps

module alu_unit
    import exec_pkg::*;
(
    input  alu_packet_t packet,
    output cdb_packet_t result
);

    localparam int shamt_width = $clog2(xlen);

    logic [xlen-1:0]        value;
    logic [shamt_width-1:0] shamt;

    // shift amount from the low bits of src2 only
    assign shamt = packet.src2[shamt_width-1:0];

    always_comb begin
        case (packet.opcode)
            alu_add: value = packet.src1 + packet.src2;
            alu_sub: value = packet.src1 - packet.src2;
            alu_and: value = packet.src1 & packet.src2;
            alu_or:  value = packet.src1 | packet.src2;
            alu_xor: value = packet.src1 ^ packet.src2;
            alu_sll: value = packet.src1 << shamt;
            alu_srl: value = packet.src1 >> shamt;
            // signed compare, result is 0 or 1
            alu_slt: value = {{(xlen-1){1'b0}}, $signed(packet.src1) < $signed(packet.src2)};
            default: value = '0;
        endcase
    end

    always_comb begin
        result          = '0;
        result.valid    = packet.valid;
        result.dest_tag = packet.dest_tag;
        result.value    = value;
    end

endmodule

//--- branch_unit.sv
`timescale 1ns/1ps

module branch_unit
    import exec_pkg::*;
(
    input  branch_packet_t packet,
    output cdb_packet_t    cdb_out,
    output branch_result_t resolution
);

    logic            taken;
    logic [xlen-1:0] link;

    assign link = packet.pc + xlen'(4);

    always_comb begin
        case (packet.cond)
            br_beq:  taken = packet.src1 == packet.src2;
            br_bne:  taken = packet.src1 != packet.src2;
            br_blt:  taken = $signed(packet.src1) < $signed(packet.src2);
            br_bge:  taken = $signed(packet.src1) >= $signed(packet.src2);
            br_bltu: taken = packet.src1 < packet.src2;
            br_bgeu: taken = packet.src1 >= packet.src2;
            default: taken = 1'b0;
        endcase
    end

    // invalid packets give an all-zero record
    always_comb begin
        resolution = '0;
        cdb_out    = '0;
        if (packet.valid) begin
            resolution.valid      = 1'b1;
            resolution.b_id       = packet.b_id;
            resolution.taken      = taken;
            resolution.mispredict = taken != packet.predicted_taken;
            resolution.target     = taken ? packet.pc + packet.offset : link;
            // link write only for a real destination
            cdb_out.valid    = packet.dest_tag != '0;
            cdb_out.dest_tag = packet.dest_tag;
            cdb_out.value    = link;
        end
    end

endmodule

//--- complete_arbiter.sv
`timescale 1ns/1ps

module complete_arbiter
    import exec_pkg::*;
#(
    parameter int num_cdb = 2
) (
    input  cdb_packet_t               branch_cdb,
    input  cdb_packet_t               alu_cdb,
    input  cdb_packet_t               mult_cdb,
    output cdb_packet_t [num_cdb-1:0] next_cdb,
    output logic                      mult_grant
);

    logic dup_tag;

    // lowest free slot first, branch then alu then mult
    always_comb begin
        int slot;
        next_cdb   = '0;
        mult_grant = 1'b0;
        slot       = 0;
        if (branch_cdb.valid) begin
            next_cdb[slot] = branch_cdb;
            slot++;
        end
        if (alu_cdb.valid) begin
            next_cdb[slot] = alu_cdb;
            slot++;
        end
        // multiplier only gets what is left over
        if (mult_cdb.valid && slot < num_cdb) begin
            next_cdb[slot] = mult_cdb;
            mult_grant     = 1'b1;
        end
    end

    // two writers of one physical tag would corrupt the register file
    always_comb begin
        dup_tag = 1'b0;
        for (int i = 0; i < num_cdb; i++) begin
            for (int j = i + 1; j < num_cdb; j++) begin
                if (next_cdb[i].valid && next_cdb[j].valid &&
                    next_cdb[i].dest_tag == next_cdb[j].dest_tag) begin
                    dup_tag = 1'b1;
                end
            end
        end
    end

    always_comb begin
        a_unique_tags: assert final (!dup_tag)
            else $error("complete_arbiter: same dest_tag in two slots");
    end

endmodule

//--- exec_pkg.sv
package exec_pkg;

    // datapath and tag sizes
    localparam int xlen        = 32;
    localparam int tag_width   = 6;
    localparam int bmask_width = 4;

    typedef enum logic [2:0] {
        alu_add = 3'd0,
        alu_sub = 3'd1,
        alu_and = 3'd2,
        alu_or  = 3'd3,
        alu_xor = 3'd4,
        alu_sll = 3'd5,
        alu_srl = 3'd6,
        alu_slt = 3'd7
    } alu_op_e;

    // codes 6 and 7 are unused and never taken
    typedef enum logic [2:0] {
        br_beq  = 3'd0,
        br_bne  = 3'd1,
        br_blt  = 3'd2,
        br_bge  = 3'd3,
        br_bltu = 3'd4,
        br_bgeu = 3'd5
    } branch_cond_e;

    typedef struct packed {
        logic                 valid;
        alu_op_e              opcode;
        logic [xlen-1:0]      src1;
        logic [xlen-1:0]      src2;
        logic [tag_width-1:0] dest_tag;
    } alu_packet_t;

    typedef struct packed {
        logic                   valid;
        logic [xlen-1:0]        src1;
        logic [xlen-1:0]        src2;
        logic [tag_width-1:0]   dest_tag;
        logic [bmask_width-1:0] b_mask;
    } mult_packet_t;

    // b_id is the one-hot mask bit owned by this branch
    typedef struct packed {
        logic                   valid;
        branch_cond_e           cond;
        logic [xlen-1:0]        src1;
        logic [xlen-1:0]        src2;
        logic [xlen-1:0]        pc;
        logic [xlen-1:0]        offset;
        logic                   predicted_taken;
        logic [tag_width-1:0]   dest_tag;
        logic [bmask_width-1:0] b_id;
    } branch_packet_t;

    typedef struct packed {
        logic                 valid;
        logic [tag_width-1:0] dest_tag;
        logic [xlen-1:0]      value;
    } cdb_packet_t;

    typedef struct packed {
        logic                   valid;
        logic [bmask_width-1:0] b_id;
        logic                   taken;
        logic                   mispredict;
        logic [xlen-1:0]        target;
    } branch_result_t;

endpackage

//--- execute_stage.sv
`timescale 1ns/1ps

module execute_stage
    import exec_pkg::*;
#(
    parameter int num_cdb     = 2,
    parameter int mult_stages = 4
) (
    input  logic                      clock,
    input  logic                      reset,

    // issue side
    input  alu_packet_t               alu_issue,
    input  mult_packet_t              mult_issue,
    input  branch_packet_t            branch_issue,
    output logic                      mult_free,

    // branch stack side
    input  logic [bmask_width-1:0]    b_mask_resolve,
    input  logic                      b_mispredict,

    output cdb_packet_t [num_cdb-1:0] cdb,
    output branch_result_t            branch_out
);

    // alu and branch must always find a slot
    if (num_cdb < 2) begin : g_num_cdb_check
        $fatal(1, "execute_stage: num_cdb must be at least 2");
    end

    alu_packet_t               alu_issue_q;
    branch_packet_t            branch_issue_q;
    cdb_packet_t               alu_result;
    cdb_packet_t               branch_cdb;
    cdb_packet_t               mult_result;
    branch_result_t            branch_resolution;
    cdb_packet_t [num_cdb-1:0] next_cdb;
    logic                      mult_grant;

    // issue registers, cdb and branch record
    always_ff @(posedge clock) begin
        if (reset) begin
            alu_issue_q    <= '0;
            branch_issue_q <= '0;
            cdb            <= '0;
            branch_out     <= '0;
        end else begin
            alu_issue_q    <= alu_issue;
            branch_issue_q <= branch_issue;
            cdb            <= next_cdb;
            branch_out     <= branch_resolution;
        end
    end

    alu_unit alu_i (
        .packet (alu_issue_q),
        .result (alu_result)
    );

    // fed straight from issue, the first pipe stage is its register
    mult_unit #(
        .mult_stages (mult_stages)
    ) mult_i (
        .clock          (clock),
        .reset          (reset),
        .packet         (mult_issue),
        .grant          (mult_grant),
        .b_mask_resolve (b_mask_resolve),
        .b_mispredict   (b_mispredict),
        .free           (mult_free),
        .result         (mult_result)
    );

    branch_unit branch_i (
        .packet     (branch_issue_q),
        .cdb_out    (branch_cdb),
        .resolution (branch_resolution)
    );

    complete_arbiter #(
        .num_cdb (num_cdb)
    ) arbiter_i (
        .branch_cdb (branch_cdb),
        .alu_cdb    (alu_result),
        .mult_cdb   (mult_result),
        .next_cdb   (next_cdb),
        .mult_grant (mult_grant)
    );

endmodule

//--- mult_unit.sv
`timescale 1ns/1ps

module mult_unit
    import exec_pkg::*;
#(
    parameter int mult_stages = 4
) (
    input  logic                   clock,
    input  logic                   reset,
    input  mult_packet_t           packet,
    input  logic                   grant,
    input  logic [bmask_width-1:0] b_mask_resolve,
    input  logic                   b_mispredict,
    output logic                   free,
    output cdb_packet_t            result
);

    // multiplier bits consumed per stage
    localparam int chunk = (xlen + mult_stages - 1) / mult_stages;

    typedef struct packed {
        logic [tag_width-1:0]   dest_tag;
        logic [bmask_width-1:0] b_mask;
        logic [xlen-1:0]        mcand;
        logic [xlen-1:0]        mplier;
        logic [xlen-1:0]        acc;
    } stage_t;

    stage_t [mult_stages-1:0] stage_q;
    stage_t [mult_stages-1:0] stage_d;
    logic   [mult_stages-1:0] valid_q;
    logic   [mult_stages-1:0] valid_d;
    stage_t                   entry;
    logic                     last_live;
    logic                     stall;

    // one shift-and-add step over the next chunk of the multiplier
    function automatic stage_t mac_step(stage_t s);
        stage_t r;
        r        = s;
        r.acc    = s.acc + s.mcand * s.mplier[chunk-1:0];
        r.mcand  = s.mcand << chunk;
        r.mplier = s.mplier >> chunk;
        return r;
    endfunction

    always_comb begin
        entry          = '0;
        entry.dest_tag = packet.dest_tag;
        entry.b_mask   = packet.b_mask;
        entry.mcand    = packet.src1;
        entry.mplier   = packet.src2;
    end

    // a product squashed this cycle must not win the bus
    assign last_live = valid_q[mult_stages-1] &&
                       !(b_mispredict && |(stage_q[mult_stages-1].b_mask & b_mask_resolve));
    assign stall     = last_live && !grant;
    assign free      = !stall;

    always_comb begin
        stage_d = stage_q;
        valid_d = valid_q;
        if (!stall) begin
            stage_d[0] = mac_step(entry);
            valid_d[0] = packet.valid;
            for (int i = 1; i < mult_stages; i++) begin
                stage_d[i] = mac_step(stage_q[i-1]);
                valid_d[i] = valid_q[i-1];
            end
        end
        // squash or resolve, also while frozen
        for (int i = 0; i < mult_stages; i++) begin
            if (b_mispredict && |(stage_d[i].b_mask & b_mask_resolve)) begin
                valid_d[i] = 1'b0;
            end
            stage_d[i].b_mask = stage_d[i].b_mask & ~b_mask_resolve;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            valid_q <= '0;
        end else begin
            valid_q <= valid_d;
        end
    end

    always_ff @(posedge clock) begin
        stage_q <= stage_d;
    end

    always_comb begin
        result          = '0;
        result.valid    = last_live;
        result.dest_tag = stage_q[mult_stages-1].dest_tag;
        result.value    = stage_q[mult_stages-1].acc;
    end

    // issue logic must honour free
    a_no_issue_when_busy: assert property (@(posedge clock) disable iff (reset)
        packet.valid |-> free)
        else $error("mult_unit: packet issued while busy");

endmodule

//--- sources.f
exec_pkg.sv
alu_unit.sv
mult_unit.sv
branch_unit.sv
complete_arbiter.sv
execute_stage.sv
tb_execute_stage.sv

//--- tb_execute_stage.sv
`timescale 1ns/1ps

module tb_execute_stage;
    import exec_pkg::*;

    localparam int num_cdb      = 2;
    localparam int mult_stages  = 4;
    localparam int clock_period = 100;
    localparam int hold_cycles  = 6;
    localparam int wait_limit   = 2 * mult_stages + hold_cycles;
    // reset, reset check, alu, branch, pipeline, back-pressure, squash
    localparam int test_cycles  = 5 + 1 + 8 * 2 + 24 * 2 + (3 + mult_stages)
                                + (hold_cycles + 2 + 2 * wait_limit) + (5 + wait_limit);

    logic                      clock;
    logic                      reset;
    alu_packet_t               alu_issue;
    mult_packet_t              mult_issue;
    branch_packet_t            branch_issue;
    logic [bmask_width-1:0]    b_mask_resolve;
    logic                      b_mispredict;
    logic                      mult_free;
    cdb_packet_t [num_cdb-1:0] cdb;
    branch_result_t            branch_out;

    int error_count;
    int tests_run;
    int tests_failed;

    execute_stage #(
        .num_cdb     (num_cdb),
        .mult_stages (mult_stages)
    ) dut_i (
        .clock          (clock),
        .reset          (reset),
        .alu_issue      (alu_issue),
        .mult_issue     (mult_issue),
        .branch_issue   (branch_issue),
        .mult_free      (mult_free),
        .b_mask_resolve (b_mask_resolve),
        .b_mispredict   (b_mispredict),
        .cdb            (cdb),
        .branch_out     (branch_out)
    );

    initial begin
        clock = 1'b0;
        forever #(clock_period / 2) clock = ~clock;
    end

    initial begin
        #(test_cycles * 2 * clock_period);
        $display("watchdog expired after %0d cycles, a test is stuck", test_cycles * 2);
        $display("Simulation failed");
        $finish;
    end

    // reference model
    function automatic logic [xlen-1:0] alu_expected(alu_op_e op, logic [xlen-1:0] a,
                                                     logic [xlen-1:0] b);
        logic [xlen-1:0] r;
        case (op)
            alu_add: r = a + b;
            alu_sub: r = a - b;
            alu_and: r = a & b;
            alu_or:  r = a | b;
            alu_xor: r = a ^ b;
            alu_sll: r = a << b[4:0];
            alu_srl: r = a >> b[4:0];
            alu_slt: r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            default: r = '0;
        endcase
        return r;
    endfunction

    function automatic logic branch_taken(branch_cond_e cond, logic [xlen-1:0] a,
                                          logic [xlen-1:0] b);
        case (cond)
            br_beq:  return a == b;
            br_bne:  return a != b;
            br_blt:  return $signed(a) < $signed(b);
            br_bge:  return $signed(a) >= $signed(b);
            br_bltu: return a < b;
            br_bgeu: return a >= b;
            default: return 1'b0;
        endcase
    endfunction

    // low word of the unsigned product
    function automatic logic [xlen-1:0] mult_expected(logic [xlen-1:0] a, logic [xlen-1:0] b);
        logic [2*xlen-1:0] full;
        full = {{xlen{1'b0}}, a} * {{xlen{1'b0}}, b};
        return full[xlen-1:0];
    endfunction

    function automatic cdb_packet_t make_cdb(logic [tag_width-1:0] tag, logic [xlen-1:0] value);
        cdb_packet_t p;
        p.valid    = 1'b1;
        p.dest_tag = tag;
        p.value    = value;
        return p;
    endfunction

    task automatic tick();
        @(posedge clock);
        #1;
    endtask

    task automatic clear_inputs();
        alu_issue      = '0;
        mult_issue     = '0;
        branch_issue   = '0;
        b_mask_resolve = '0;
        b_mispredict   = 1'b0;
    endtask

    task automatic report_mismatch(string name, logic [63:0] got, logic [63:0] expected);
        $display("Fail %s: got %h, expected %h", name, got, expected);
        error_count++;
    endtask

    task automatic report_problem(string what);
        $display("Error: %s", what);
        error_count++;
    endtask

    task automatic finish_test(string name, int errors_before);
        tests_run++;
        if (error_count == errors_before) begin
            $display("%s: pass", name);
        end else begin
            tests_failed++;
            $display("%s: %0d errors", name, error_count - errors_before);
        end
    endtask

    task automatic expect_cdb_empty(string when);
        for (int s = 0; s < num_cdb; s++) begin
            if (cdb[s].valid !== 1'b0) begin
                report_mismatch($sformatf("cdb[%0d].valid %s", s, when),
                                64'(cdb[s].valid), 64'd0);
            end
        end
    endtask

    // watch the bus until the product shows up with no other writer in between
    task automatic wait_for_product(logic [tag_width-1:0] tag, logic [xlen-1:0] value);
        bit found;
        int cycles;
        found  = 1'b0;
        cycles = 0;
        while (!found && cycles < wait_limit) begin
            tick();
            cycles++;
            for (int s = 0; s < num_cdb; s++) begin
                if (cdb[s].valid && cdb[s].dest_tag !== tag) begin
                    report_mismatch($sformatf("cdb[%0d].dest_tag", s),
                                    64'(cdb[s].dest_tag), 64'(tag));
                end else if (cdb[s].valid) begin
                    found = 1'b1;
                    if (cdb[s].value !== value) begin
                        report_mismatch($sformatf("cdb[%0d].value", s),
                                        64'(cdb[s].value), 64'(value));
                    end
                end
            end
        end
        if (!found) begin
            report_problem($sformatf("product for tag %0d never reached the cdb", tag));
        end
    endtask

    task automatic test_reset_values();
        int errors_before;
        errors_before = error_count;
        for (int s = 0; s < num_cdb; s++) begin
            if (cdb[s] !== '0) begin
                report_mismatch($sformatf("cdb[%0d]", s), 64'(cdb[s]), 64'd0);
            end
        end
        if (branch_out !== '0) begin
            report_mismatch("branch_out", 64'(branch_out), 64'd0);
        end
        if (mult_free !== 1'b1) begin
            report_mismatch("mult_free", 64'(mult_free), 64'd1);
        end
        finish_test("reset_values", errors_before);
    endtask

    task automatic test_alu_ops();
        int              errors_before;
        alu_op_e         op;
        logic [xlen-1:0] a;
        logic [xlen-1:0] b;
        cdb_packet_t     expected;
        errors_before = error_count;
        for (int i = 0; i < 8; i++) begin
            op = alu_op_e'(3'(i));
            a  = $urandom;
            b  = $urandom;
            alu_issue.valid    = 1'b1;
            alu_issue.opcode   = op;
            alu_issue.src1     = a;
            alu_issue.src2     = b;
            alu_issue.dest_tag = 6'(i + 1);
            tick();
            alu_issue = '0;
            tick();
            expected = make_cdb(6'(i + 1), alu_expected(op, a, b));
            if (cdb[0] !== expected) begin
                report_mismatch($sformatf("cdb[0] for %s", op.name()), 64'(cdb[0]),
                                64'(expected));
            end
            if (cdb[1].valid !== 1'b0) begin
                report_mismatch("cdb[1].valid", 64'(cdb[1].valid), 64'd0);
            end
        end
        finish_test("alu_ops", errors_before);
    endtask

    task automatic test_branches();
        int                   errors_before;
        branch_packet_t       p;
        branch_result_t       exp_res;
        cdb_packet_t          exp_cdb;
        errors_before = error_count;
        for (int c = 0; c < 6; c++) begin
            for (int i = 0; i < 4; i++) begin
                // bit 0 forces equal operands and bit 1 sets the prediction
                p.valid           = 1'b1;
                p.cond            = branch_cond_e'(3'(c));
                p.src1            = $urandom;
                p.src2            = i[0] ? p.src1 : $urandom;
                p.pc              = $urandom & 32'hffff_fffc;
                p.offset          = $urandom & 32'h0000_0ffc;
                p.predicted_taken = i[1];
                p.dest_tag        = (i[0] ^ i[1]) ? 6'(10 + c) : 6'd0;
                p.b_id            = 4'b0001 << (c % 4);
                branch_issue = p;
                tick();
                branch_issue = '0;
                tick();
                exp_res.valid      = 1'b1;
                exp_res.b_id       = p.b_id;
                exp_res.taken      = branch_taken(p.cond, p.src1, p.src2);
                exp_res.mispredict = exp_res.taken != p.predicted_taken;
                exp_res.target     = exp_res.taken ? p.pc + p.offset : p.pc + 32'd4;
                exp_cdb = (p.dest_tag != 0) ? make_cdb(p.dest_tag, p.pc + 32'd4) : '0;
                if (branch_out !== exp_res) begin
                    report_mismatch($sformatf("branch_out for %s", p.cond.name()),
                                    64'(branch_out), 64'(exp_res));
                end
                if (cdb[0] !== exp_cdb) begin
                    report_mismatch("cdb[0] link", 64'(cdb[0]), 64'(exp_cdb));
                end
            end
        end
        finish_test("branches", errors_before);
    endtask

    task automatic test_mult_pipeline();
        int           errors_before;
        int           idx;
        mult_packet_t pkts [3];
        cdb_packet_t  expected;
        errors_before = error_count;
        for (int i = 0; i < 3; i++) begin
            pkts[i].valid    = 1'b1;
            pkts[i].src1     = $urandom;
            pkts[i].src2     = $urandom;
            pkts[i].dest_tag = 6'(20 + i);
            pkts[i].b_mask   = '0;
        end
        if (mult_free !== 1'b1) begin
            report_problem("multiplier busy before the first issue");
        end
        for (int c = 0; c < 3 + mult_stages; c++) begin
            if (c < 3) begin
                mult_issue = pkts[c];
            end else begin
                mult_issue = '0;
            end
            tick();
            if (c >= mult_stages) begin
                idx      = c - mult_stages;
                expected = make_cdb(pkts[idx].dest_tag,
                                    mult_expected(pkts[idx].src1, pkts[idx].src2));
                if (cdb[0] !== expected) begin
                    report_mismatch($sformatf("cdb[0] product %0d", idx), 64'(cdb[0]),
                                    64'(expected));
                end
            end else if (cdb[0].valid !== 1'b0) begin
                report_problem($sformatf("product on the cdb after only %0d edges", c + 1));
            end
        end
        finish_test("mult_pipeline", errors_before);
    endtask

    task automatic test_back_pressure();
        int             errors_before;
        alu_packet_t    alu_pk [hold_cycles];
        branch_packet_t br_pk [hold_cycles];
        mult_packet_t   m0;
        mult_packet_t   m1;
        cdb_packet_t    exp_br;
        cdb_packet_t    exp_alu;
        errors_before = error_count;
        m0 = '{valid: 1'b1, src1: $urandom, src2: $urandom, dest_tag: 6'd60, b_mask: 4'b0};
        m1 = '{valid: 1'b1, src1: $urandom, src2: $urandom, dest_tag: 6'd61, b_mask: 4'b0};
        for (int j = 0; j < hold_cycles; j++) begin
            alu_pk[j]          = '0;
            alu_pk[j].valid    = 1'b1;
            alu_pk[j].opcode   = alu_op_e'(3'($urandom));
            alu_pk[j].src1     = $urandom;
            alu_pk[j].src2     = $urandom;
            alu_pk[j].dest_tag = 6'(30 + j);
            br_pk[j]           = '0;
            br_pk[j].valid     = 1'b1;
            br_pk[j].cond      = br_bne;
            br_pk[j].src1      = $urandom;
            br_pk[j].src2      = $urandom;
            br_pk[j].pc        = $urandom & 32'hffff_fffc;
            br_pk[j].dest_tag  = 6'(40 + j);
            br_pk[j].b_id      = 4'b1000;
        end
        mult_issue = m0;
        tick();
        for (int j = 0; j <= hold_cycles; j++) begin
            if (j == 0) begin
                mult_issue = m1;
            end else begin
                mult_issue = '0;
            end
            if (j < hold_cycles) begin
                alu_issue    = alu_pk[j];
                branch_issue = br_pk[j];
            end else begin
                alu_issue    = '0;
                branch_issue = '0;
            end
            tick();
            // branch link in slot 0 and alu in slot 1
            if (j >= 1) begin
                exp_br  = make_cdb(br_pk[j-1].dest_tag, br_pk[j-1].pc + 32'd4);
                exp_alu = make_cdb(alu_pk[j-1].dest_tag, alu_expected(alu_pk[j-1].opcode,
                                   alu_pk[j-1].src1, alu_pk[j-1].src2));
                if (cdb[0] !== exp_br) begin
                    report_mismatch("cdb[0]", 64'(cdb[0]), 64'(exp_br));
                end
                if (cdb[1] !== exp_alu) begin
                    report_mismatch("cdb[1]", 64'(cdb[1]), 64'(exp_alu));
                end
            end
            if (j >= mult_stages - 2 && j < hold_cycles) begin
                if (mult_free !== 1'b0) begin
                    report_mismatch("mult_free", 64'(mult_free), 64'd0);
                end
            end
        end
        wait_for_product(m0.dest_tag, mult_expected(m0.src1, m0.src2));
        wait_for_product(m1.dest_tag, mult_expected(m1.src1, m1.src2));
        finish_test("back_pressure", errors_before);
    endtask

    task automatic test_squash_resolve();
        int           errors_before;
        mult_packet_t ma;
        mult_packet_t mb;
        errors_before = error_count;
        ma = '{valid: 1'b1, src1: $urandom, src2: $urandom, dest_tag: 6'd50, b_mask: 4'b0001};
        mb = '{valid: 1'b1, src1: $urandom, src2: $urandom, dest_tag: 6'd51, b_mask: 4'b0010};
        mult_issue = ma;
        tick();
        mult_issue = mb;
        tick();
        mult_issue     = '0;
        b_mask_resolve = 4'b0001;
        b_mispredict   = 1'b1;
        tick();
        expect_cdb_empty("during squash");
        b_mask_resolve = 4'b0010;
        b_mispredict   = 1'b0;
        tick();
        expect_cdb_empty("after squash");
        // bit already cleared so this mispredict leaves mb alone
        b_mask_resolve = 4'b0010;
        b_mispredict   = 1'b1;
        tick();
        // ma would sit on the bus here had it survived
        expect_cdb_empty("when the squashed product was due");
        clear_inputs();
        wait_for_product(mb.dest_tag, mult_expected(mb.src1, mb.src2));
        finish_test("squash_resolve", errors_before);
    endtask

    initial begin
        error_count  = 0;
        tests_run    = 0;
        tests_failed = 0;
        void'($urandom(32'h45d));
        reset        = 1'b1;
        clear_inputs();
        repeat (4) @(posedge clock);
        #1;
        reset = 1'b0;

        test_reset_values();
        test_alu_ops();
        test_branches();
        test_mult_pipeline();
        test_back_pressure();
        test_squash_resolve();

        $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, error_count);
        if (error_count == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule
